/* source/padring_pkg.sv */
package padring_pkg;

    // Latch word as seen by the pad ring
    typedef logic [11:0] cfg_word_t;

    localparam int CFG_ADDR_W = 6;      // Up to 60 user words plus 4 done words
    localparam int SERVICE_PADS = 4;    // Pads in front of the user pads

    // Electrical attributes, same bit order as the pad cell pins
    typedef struct packed {
        logic       slow_sel;
        logic       vtrip_sel;
        logic       ib_mode_sel;
        logic [2:0] dm;
    } pad_attr_t;

    // Per-pad reset defaults, 13 bits
    typedef struct packed {
        logic      cfg_en;     // Attributes may come from a latch word
        logic      out_val;
        logic      oe_val;     // Fixed oeb level
        logic      ie_val;     // Fixed ieb level
        logic      ovr_out;
        logic      ovr_oe;
        logic      ovr_ie;
        pad_attr_t attr;
    } pad_default_t;

    typedef struct packed {
        logic out;
        logic oeb;
        logic ieb;
    } pad_drive_t;

    typedef enum logic [2:0] {
        ROLE_DONE_OVR  = 3'd0,
        ROLE_DONE_LED  = 3'd1,
        ROLE_HEART_LED = 3'd2,
        ROLE_WR_LED    = 3'd3,
        ROLE_USER      = 3'd4
    } pad_role_e;

    // Upper word sits at the highest done address
    localparam logic [47:0] DONE_MAGIC = 48'hFEED_BADC_A77E;

    localparam pad_default_t DEF_INPUT   = 13'h04C1;  // Input only, dm 001
    localparam pad_default_t DEF_OUTPUT  = 13'h02C6;  // Push-pull output, dm 110
    localparam pad_default_t DEF_USER_IO = 13'h1006;  // Bidir, attributes configurable

    // Pad index to role
    function automatic pad_role_e pad_role(input int idx);
        case (idx)
            0:       return ROLE_DONE_OVR;
            1:       return ROLE_DONE_LED;
            2:       return ROLE_HEART_LED;
            3:       return ROLE_WR_LED;
            default: return ROLE_USER;
        endcase
    endfunction

    function automatic pad_default_t role_defaults(input pad_role_e role);
        case (role)
            ROLE_DONE_OVR: return DEF_INPUT;
            ROLE_USER:     return DEF_USER_IO;
            default:       return DEF_OUTPUT;  // The three status LEDs
        endcase
    endfunction

endpackage

/* source/cfg_latch_bank.sv */
`timescale 1ns/1ps

module cfg_latch_bank #(
    parameter int USER_PADS = 8
) (
    input  logic                                     fabric_clk,
    input  logic                                     resetb,
    input  logic                                     cfg_wr_i,
    input  logic [padring_pkg::CFG_ADDR_W-1:0]       cfg_addr_i,
    input  padring_pkg::cfg_word_t                   cfg_data_i,
    output padring_pkg::cfg_word_t [USER_PADS+3:0]   words_o,
    output logic                                     wr_pulse_o
);
    import padring_pkg::*;

    // User words first, then the four done words
    localparam int NUM_WORDS = USER_PADS + 4;

    cfg_word_t [NUM_WORDS-1:0] words_q;
    logic                      addr_valid;

    // Anything past the done words is dropped
    assign addr_valid = (int'(cfg_addr_i) < NUM_WORDS);

    // Same cycle as the register write so the LED tracks the latch contents
    assign wr_pulse_o = cfg_wr_i && addr_valid;

    always_ff @(posedge fabric_clk or negedge resetb) begin
        if (!resetb) begin
            words_q <= '0;
        end else begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                if (wr_pulse_o && (cfg_addr_i == CFG_ADDR_W'(i))) begin
                    words_q[i] <= cfg_data_i;
                end
            end
        end
    end

    assign words_o = words_q;

endmodule

/* source/fabric_status.sv */
`timescale 1ns/1ps

module fabric_status #(
    parameter int HEART_BITS = 22
) (
    input  logic                             fabric_clk,
    input  logic                             resetb,
    input  padring_pkg::cfg_word_t [3:0]     done_words_i,
    input  logic                             done_ovr_i,
    input  logic                             wr_pulse_i,
    output logic                             done_o,
    output logic                             heart_o,
    output logic                             wr_led_o
);
    import padring_pkg::*;

    logic [HEART_BITS-1:0] beat_cnt;
    logic                  magic_ok;
    logic                  wr_led_q;

    // Four words concatenated, word 3 on top
    assign magic_ok = (done_words_i == DONE_MAGIC);

    // Override pad forces done without any configuration
    assign done_o = magic_ok | done_ovr_i;

    // Free-running heartbeat so the clock can be seen on a pad
    always_ff @(posedge fabric_clk or negedge resetb) begin
        if (!resetb) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign heart_o = beat_cnt[HEART_BITS-1];  // Half period is 2^(HEART_BITS-1)

    // One toggle per accepted latch write
    always_ff @(posedge fabric_clk or negedge resetb) begin
        if (!resetb) begin
            wr_led_q <= 1'b0;
        end else if (wr_pulse_i) begin
            wr_led_q <= ~wr_led_q;
        end
    end

    assign wr_led_o = wr_led_q;

endmodule

/* source/pad_ctrl.sv */
`timescale 1ns/1ps

module pad_ctrl #(
    parameter padring_pkg::pad_default_t DEFAULTS = padring_pkg::DEF_USER_IO
) (
    input  logic                     done_i,
    input  padring_pkg::cfg_word_t   cfg_i,
    input  padring_pkg::pad_drive_t  sys_i,
    output padring_pkg::pad_drive_t  pad_o,
    output padring_pkg::pad_attr_t   attr_o
);
    import padring_pkg::*;

    pad_attr_t cfg_attr;
    logic      use_cfg;

    // Only the low six bits of a latch word carry attributes
    assign cfg_attr = pad_attr_t'(cfg_i[5:0]);

    // Configured attributes stay hidden until the fabric reports done
    assign use_cfg = DEFAULTS.cfg_en && done_i;

    // Each drive bit either fixed by the defaults or taken from the system side
    always_comb begin
        pad_o.out = DEFAULTS.ovr_out ? DEFAULTS.out_val : sys_i.out;
        pad_o.oeb = DEFAULTS.ovr_oe  ? DEFAULTS.oe_val  : sys_i.oeb;
        pad_o.ieb = DEFAULTS.ovr_ie  ? DEFAULTS.ie_val  : sys_i.ieb;
    end

    assign attr_o = use_cfg ? cfg_attr : DEFAULTS.attr;

endmodule

/* source/padring_top.sv */
`timescale 1ns/1ps

module padring_top #(
    parameter int   USER_PADS  = 8,
    parameter int   HEART_BITS = 22,
    localparam int  NUM_PADS   = padring_pkg::SERVICE_PADS + USER_PADS
) (
    input  logic                                     fabric_clk,
    input  logic                                     resetb,

    // Latch write port
    input  logic                                     cfg_wr_i,
    input  logic [padring_pkg::CFG_ADDR_W-1:0]       cfg_addr_i,
    input  padring_pkg::cfg_word_t                   cfg_data_i,

    // User side of the pads
    input  logic [USER_PADS-1:0]                     user_out_i,
    input  logic [USER_PADS-1:0]                     user_t_i,   // High means input
    output logic [USER_PADS-1:0]                     user_in_o,

    // Pad side
    input  logic [NUM_PADS-1:0]                      pad_in_i,
    output padring_pkg::pad_drive_t [NUM_PADS-1:0]   pad_drive_o,
    output padring_pkg::pad_attr_t  [NUM_PADS-1:0]   pad_attr_o
);
    import padring_pkg::*;

    cfg_word_t [USER_PADS+3:0]  cfg_words;
    logic                       wr_pulse;
    logic                       done;
    logic                       heart;
    logic                       wr_led;
    logic [SERVICE_PADS-1:0]    svc_out;

    cfg_latch_bank #(
        .USER_PADS (USER_PADS)
    ) i_cfg_latch_bank (
        .fabric_clk (fabric_clk),
        .resetb     (resetb),
        .cfg_wr_i   (cfg_wr_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_data_i (cfg_data_i),
        .words_o    (cfg_words),
        .wr_pulse_o (wr_pulse)
    );

    fabric_status #(
        .HEART_BITS (HEART_BITS)
    ) i_fabric_status (
        .fabric_clk   (fabric_clk),
        .resetb       (resetb),
        .done_words_i (cfg_words[USER_PADS +: 4]),   // Done words follow the user words
        .done_ovr_i   (pad_in_i[int'(ROLE_DONE_OVR)]),
        .wr_pulse_i   (wr_pulse),
        .done_o       (done),
        .heart_o      (heart),
        .wr_led_o     (wr_led)
    );

    // Status bits by service pad index, pad 0 is an input and drives nothing
    assign svc_out = {wr_led, heart, done, 1'b0};

    for (genvar p = 0; p < NUM_PADS; p++) begin : g_pad
        localparam pad_role_e ROLE = pad_role(p);

        pad_drive_t sys_drive;
        cfg_word_t  pad_cfg;

        if (ROLE == ROLE_USER) begin : g_user
            assign sys_drive.out = user_out_i[p-SERVICE_PADS];
            assign sys_drive.oeb = user_t_i[p-SERVICE_PADS];
            assign sys_drive.ieb = ~user_t_i[p-SERVICE_PADS];
            assign pad_cfg       = cfg_words[p-SERVICE_PADS];
        end else begin : g_service
            // Override input versus LED outputs
            assign sys_drive.out = svc_out[p];
            assign sys_drive.oeb = (ROLE == ROLE_DONE_OVR);
            assign sys_drive.ieb = (ROLE != ROLE_DONE_OVR);
            assign pad_cfg       = '0;  // cfg_en is clear for these
        end

        pad_ctrl #(
            .DEFAULTS (role_defaults(ROLE))
        ) i_pad_ctrl (
            .done_i (done),
            .cfg_i  (pad_cfg),
            .sys_i  (sys_drive),
            .pad_o  (pad_drive_o[p]),
            .attr_o (pad_attr_o[p])
        );
    end

    assign user_in_o = pad_in_i[NUM_PADS-1:SERVICE_PADS];

endmodule

/* tests/padring_chk.sv */
`timescale 1ns/1ps

module padring_chk #(
    parameter int NUM_PADS = 12
) (
    input  logic                                   fabric_clk,
    input  logic                                   resetb,
    input  logic                                   done_i,
    input  logic                                   heart_i,
    input  padring_pkg::pad_drive_t [NUM_PADS-1:0] pad_drive_i
);

    logic [NUM_PADS-1:0] both_low;

    // Pads driving out with the input buffer also enabled
    always_comb begin
        for (int p = 0; p < NUM_PADS; p++) begin
            both_low[p] = !pad_drive_i[p].oeb && !pad_drive_i[p].ieb;
        end
    end

    no_drive_contention: assert property (@(posedge fabric_clk) both_low == '0)
        else $error("oeb and ieb both low on pads %b", both_low);

    done_led_follows: assert property (@(posedge fabric_clk) pad_drive_i[1].out == done_i)
        else $error("Done LED pad differs from done");

    heart_low_in_reset: assert property (@(posedge fabric_clk) !resetb |-> !heart_i)
        else $error("Heartbeat high during reset");

endmodule

bind padring_top padring_chk #(
    .NUM_PADS (NUM_PADS)
) i_padring_chk (
    .fabric_clk  (fabric_clk),
    .resetb      (resetb),
    .done_i      (done),
    .heart_i     (heart),
    .pad_drive_i (pad_drive_o)
);

/* tests/padring_tb.sv */
`timescale 1ns/1ps

module padring_tb;
    import padring_pkg::*;

    localparam int USER_PADS  = 8;
    localparam int HEART_BITS = 4;
    localparam int NUM_PADS   = SERVICE_PADS + USER_PADS;
    localparam int NUM_WORDS  = USER_PADS + 4;
    localparam int CLK_PERIOD = 100;
    localparam int HEART_HALF = 2 ** (HEART_BITS - 1);

    // Default attributes by pad role
    localparam logic [5:0] ATTR_INPUT  = 6'h01;
    localparam logic [5:0] ATTR_OUTPUT = 6'h06;
    localparam logic [5:0] ATTR_USER   = 6'h06;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_PADS,
        OP_IDLE,
        OP_CHECK
    } op_e;

    // Check rows reuse addr as pad index and data as expected attributes
    typedef struct packed {
        op_e         op;
        logic [5:0]  addr;
        logic [11:0] data;
        logic        pin0;      // Done override pad level
        logic        exp_done;
    } row_t;

    logic                             fabric_clk;
    logic                             resetb;
    logic                             cfg_wr_i;
    logic [CFG_ADDR_W-1:0]            cfg_addr_i;
    cfg_word_t                        cfg_data_i;
    logic [USER_PADS-1:0]             user_out_i;
    logic [USER_PADS-1:0]             user_t_i;
    logic [USER_PADS-1:0]             user_in_o;
    logic [NUM_PADS-1:0]              pad_in_i;
    pad_drive_t [NUM_PADS-1:0]        pad_drive_o;
    pad_attr_t  [NUM_PADS-1:0]        pad_attr_o;

    row_t        rows[$];
    string       row_names[$];
    logic [11:0] shadow[NUM_WORDS];   // Words the testbench has written
    int          wr_count;
    int          cycles;              // Clock cycles since reset release
    int          n_checks;
    int          n_errors;
    int          spot_pad;
    bit          table_ready = 1'b0;

    initial begin
        fabric_clk = 1'b0;
        forever #(CLK_PERIOD / 2) fabric_clk = ~fabric_clk;
    end

    padring_top #(
        .USER_PADS  (USER_PADS),
        .HEART_BITS (HEART_BITS)
    ) i_padring_top (
        .fabric_clk  (fabric_clk),
        .resetb      (resetb),
        .cfg_wr_i    (cfg_wr_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .user_out_i  (user_out_i),
        .user_t_i    (user_t_i),
        .user_in_o   (user_in_o),
        .pad_in_i    (pad_in_i),
        .pad_drive_o (pad_drive_o),
        .pad_attr_o  (pad_attr_o)
    );

    task automatic add_row(input string name, input op_e op, input logic [5:0] addr,
                           input logic [11:0] data, input logic pin0, input logic exp_done);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.data     = data;
        r.pin0     = pin0;
        r.exp_done = exp_done;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        add_row("reset_idle",  OP_IDLE,  6'd0,  12'h000, 1'b0, 1'b0);
        add_row("rand_pads_a", OP_PADS,  6'd0,  12'h000, 1'b0, 1'b0);
        add_row("wr_user0",    OP_WRITE, 6'd0,  12'h0A5, 1'b0, 1'b0);
        add_row("wr_user1",    OP_WRITE, 6'd1,  12'h13C, 1'b0, 1'b0);
        add_row("wr_user2",    OP_WRITE, 6'd2,  12'h02B, 1'b0, 1'b0);
        add_row("wr_user3",    OP_WRITE, 6'd3,  12'hFFF, 1'b0, 1'b0);
        add_row("wr_user4",    OP_WRITE, 6'd4,  12'h011, 1'b0, 1'b0);
        add_row("wr_user5",    OP_WRITE, 6'd5,  12'h7C0, 1'b0, 1'b0);
        add_row("wr_user6",    OP_WRITE, 6'd6,  12'h03A, 1'b0, 1'b0);
        add_row("wr_user7",    OP_WRITE, 6'd7,  12'h807, 1'b0, 1'b0);
        add_row("gated_chk",   OP_CHECK, 6'd4,  12'h006, 1'b0, 1'b0);
        // Magic split FEE DBA DCA 77E, lowest word at address 8
        add_row("wr_done0",    OP_WRITE, 6'd8,  12'h77E, 1'b0, 1'b0);
        add_row("wr_done1",    OP_WRITE, 6'd9,  12'hDCA, 1'b0, 1'b0);
        add_row("wr_done2",    OP_WRITE, 6'd10, 12'hDBA, 1'b0, 1'b0);
        add_row("wr_bad_12",   OP_WRITE, 6'd12, 12'hFEE, 1'b0, 1'b0);
        add_row("wr_bad_63",   OP_WRITE, 6'd63, 12'hFEE, 1'b0, 1'b0);
        add_row("wr_done3",    OP_WRITE, 6'd11, 12'hFEE, 1'b0, 1'b1);
        add_row("cfg_chk_u0",  OP_CHECK, 6'd4,  12'h025, 1'b0, 1'b1);
        add_row("cfg_chk_u3",  OP_CHECK, 6'd7,  12'h03F, 1'b0, 1'b1);
        add_row("rand_pads_b", OP_PADS,  6'd0,  12'h000, 1'b0, 1'b1);
        add_row("wr_wrong2",   OP_WRITE, 6'd10, 12'hDBB, 1'b0, 1'b0);
        add_row("wrong_chk",   OP_CHECK, 6'd4,  12'h006, 1'b0, 1'b0);
        add_row("ovr_high",    OP_PADS,  6'd0,  12'h000, 1'b1, 1'b1);
        add_row("ovr_chk",     OP_CHECK, 6'd5,  12'h03C, 1'b1, 1'b1);
        add_row("ovr_low",     OP_PADS,  6'd0,  12'h000, 1'b0, 1'b0);
        add_row("ovr_off_chk", OP_CHECK, 6'd5,  12'h006, 1'b0, 1'b0);
        add_row("wr_fix2",     OP_WRITE, 6'd10, 12'hDBA, 1'b0, 1'b1);
        add_row("cfg_chk_u7",  OP_CHECK, 6'd11, 12'h007, 1'b0, 1'b1);
        add_row("rand_pads_c", OP_PADS,  6'd0,  12'h000, 1'b0, 1'b1);
        add_row("idle_a",      OP_IDLE,  6'd0,  12'h000, 1'b0, 1'b1);
        add_row("idle_b",      OP_IDLE,  6'd0,  12'h000, 1'b0, 1'b1);
        add_row("idle_c",      OP_IDLE,  6'd0,  12'h000, 1'b0, 1'b1);
        add_row("idle_d",      OP_IDLE,  6'd0,  12'h000, 1'b0, 1'b1);
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            OP_WRITE: begin
                cfg_wr_i   = 1'b1;
                cfg_addr_i = r.addr;
                cfg_data_i = r.data;
            end
            OP_PADS: begin
                user_out_i  = USER_PADS'($urandom);
                user_t_i    = USER_PADS'($urandom);
                pad_in_i    = NUM_PADS'($urandom);
                pad_in_i[0] = r.pin0;
            end
            default: begin
            end
        endcase
    endtask

    // Only valid addresses land in the latch and count as activity
    task automatic record_write(input row_t r);
        int idx;
        idx = int'(r.addr);
        if (idx < NUM_WORDS) begin
            shadow[idx] = r.data;
            wr_count++;
        end
    endtask

    task automatic compare(input string name, input string what,
                           input logic [15:0] exp, input logic [15:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", name, what, exp, act);
        end
    endtask

    task automatic check_outputs(input string name, input logic exp_done);
        logic [2:0] exp_drv;    // {out, oeb, ieb}
        logic [5:0] exp_attr;
        logic       exp_heart;
        int         u;
        exp_heart = ((cycles / HEART_HALF) % 2) == 1;
        for (int p = 0; p < NUM_PADS; p++) begin
            u = p - SERVICE_PADS;
            case (p)
                0: begin
                    exp_drv  = 3'b010;    // Input buffer on, output off
                    exp_attr = ATTR_INPUT;
                end
                1: begin
                    exp_drv  = {exp_done, 2'b01};
                    exp_attr = ATTR_OUTPUT;
                end
                2: begin
                    exp_drv  = {exp_heart, 2'b01};
                    exp_attr = ATTR_OUTPUT;
                end
                3: begin
                    exp_drv  = {wr_count[0], 2'b01};  // Parity of valid writes
                    exp_attr = ATTR_OUTPUT;
                end
                default: begin
                    exp_drv  = {user_out_i[u], user_t_i[u], ~user_t_i[u]};
                    exp_attr = exp_done ? shadow[u][5:0] : ATTR_USER;
                end
            endcase
            compare(name, $sformatf("pad%0d drive", p), 16'(exp_drv), 16'(pad_drive_o[p]));
            compare(name, $sformatf("pad%0d attr", p), 16'(exp_attr), 16'(pad_attr_o[p]));
        end
        compare(name, "user_in", 16'(pad_in_i[NUM_PADS-1:SERVICE_PADS]), 16'(user_in_o));
    endtask

    initial begin
        void'($urandom(59447));
        resetb     = 1'b0;
        cfg_wr_i   = 1'b0;
        cfg_addr_i = '0;
        cfg_data_i = '0;
        user_out_i = '0;
        user_t_i   = '0;
        pad_in_i   = '0;
        wr_count   = 0;
        cycles     = 0;
        n_checks   = 0;
        n_errors   = 0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            shadow[i] = '0;
        end
        build_table();
        table_ready = 1'b1;

        repeat (2) @(negedge fabric_clk);
        resetb = 1'b1;

        // One clock per row, outputs checked on the next falling edge
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            @(negedge fabric_clk);
            cycles++;
            cfg_wr_i = 1'b0;
            if (rows[i].op == OP_WRITE) begin
                record_write(rows[i]);
            end
            check_outputs(row_names[i], rows[i].exp_done);
            if (rows[i].op == OP_CHECK) begin
                spot_pad = int'(rows[i].addr);
                compare(row_names[i], "spot attr", 16'(rows[i].data[5:0]),
                        16'(pad_attr_o[spot_pad]));
            end
        end

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + 20) * CLK_PERIOD * 4);
        $display("Watchdog expired before the stimulus table completed");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* all.f */
source/padring_pkg.sv
source/cfg_latch_bank.sv
source/fabric_status.sv
source/pad_ctrl.sv
source/padring_top.sv
tests/padring_chk.sv
tests/padring_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pad ring testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module padring_tb

./obj_dir/Vpadring_tb 2>&1 | tee "$LOG"

if grep -qxF -- '>>> PASS' "$LOG"; then
    echo "Simulation finished without errors"
    exit 0
else
    echo "Simulation reported errors, see $LOG"
    exit 1
fi
